// ==== logic/PipelinePkg.sv ====
package PipelinePkg;

    // Widths with a meaning
    typedef logic [4:0]  regIdx;
    typedef logic [31:0] word;
    typedef logic [31:0] instrWord;
    typedef logic [31:0] pcValue;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOp;

    // Primary opcodes
    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2B;
    localparam logic [5:0] opBeq  = 6'h04;

    // R-type function codes
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2A;

    // All zero means nop
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic aluSrc;
        logic branch;
        aluOp aluOp;
        logic regDst;
    } ctrlBits;

    typedef struct packed {
        logic     valid;
        pcValue   pc;
        instrWord instr;
    } ifIdReg;

    // rd is the selected destination (rt for I-type)
    typedef struct packed {
        logic    valid;
        ctrlBits ctrl;
        regIdx   rs;
        regIdx   rt;
        regIdx   rd;
        word     rsVal;
        word     rtVal;
        word     imm;
    } idExReg;

    typedef struct packed {
        logic    valid;
        ctrlBits ctrl;
        regIdx   rd;
        word     aluOut;
        word     storeVal;
    } exMemReg;

    typedef struct packed {
        logic    valid;
        ctrlBits ctrl;
        regIdx   rd;
        word     result;
    } memWbReg;

endpackage

// ==== logic/ForwardingUnit.sv ====
`timescale 1ns/1ps

module ForwardingUnit (
    input  PipelinePkg::regIdx exRs,
    input  PipelinePkg::regIdx exRt,
    input  PipelinePkg::regIdx idRs,
    input  PipelinePkg::regIdx idRt,
    input  PipelinePkg::regIdx memRd,
    input  PipelinePkg::regIdx wbRd,
    input  logic               aluSrc,
    input  logic               memWriteEx,
    input  logic               regWriteMem,
    input  logic               memReadMem,
    input  logic               memWriteMem,
    input  logic               regWriteWb,
    input  logic               branch,
    output logic [1:0]         forwardA,
    output logic [1:0]         forwardB,
    output logic               forwardC,
    output logic               forwardD,
    output logic               forwardE,
    output logic               forwardF
);

    logic memLive;
    logic wbLive;

    // Producer stages that actually write a real register
    assign memLive = regWriteMem && (memRd != '0);
    assign wbLive  = regWriteWb && (wbRd != '0);

    always_comb begin
        // ALU operand A, Mem has priority
        if (memLive && (memRd == exRs)) begin
            forwardA = 2'b10;
        end else if (wbLive && (wbRd == exRs)) begin
            forwardA = 2'b01;
        end else begin
            forwardA = 2'b00;
        end

        // ALU operand B only when it is a register
        if (memLive && (memRd == exRt) && !aluSrc) begin
            forwardB = 2'b10;
        end else if (wbLive && (wbRd == exRt) && !aluSrc) begin
            forwardB = 2'b01;
        end else begin
            forwardB = 2'b00;
        end

        // Store data in Ex from Wb
        forwardC = memWriteEx && wbLive && (wbRd == exRt);
        // Store data in Mem from Wb
        forwardD = memWriteMem && wbLive && (wbRd == memRd);

        // Branch compare from Mem ALU result, loads excluded
        forwardE = branch && memLive && !memReadMem && (memRd == idRs);
        forwardF = branch && memLive && !memReadMem && (memRd == idRt);
    end

endmodule

// ==== logic/HazardDetector.sv ====
`timescale 1ns/1ps

module HazardDetector (
    input  PipelinePkg::regIdx idRs,
    input  PipelinePkg::regIdx idRt,
    input  PipelinePkg::regIdx exRd,
    input  PipelinePkg::regIdx memRd,
    input  logic               idReadsRt,
    input  logic               idBranch,
    input  logic               exMemRead,
    input  logic               exRegWrite,
    input  logic               memMemRead,
    output logic               stall
);

    logic exHitsId;
    logic memHitsId;
    logic loadUse;
    logic branchOnEx;
    logic branchOnMem;

    // Source matches against a non-zero destination
    assign exHitsId  = (exRd != '0) && ((exRd == idRs) || (exRd == idRt));
    assign memHitsId = (memRd != '0) && ((memRd == idRs) || (memRd == idRt));

    // Load in Ex feeding decode, rt only if read
    assign loadUse = exMemRead && (exRd != '0) &&
                     ((exRd == idRs) || (idReadsRt && (exRd == idRt)));

    // Branch needs operands in decode
    assign branchOnEx  = idBranch && exRegWrite && exHitsId;
    // Load data only arrives at Wb
    assign branchOnMem = idBranch && memMemRead && memHitsId;

    assign stall = loadUse || branchOnEx || branchOnMem;

endmodule

// ==== logic/ControlDecoder.sv ====
`timescale 1ns/1ps

module ControlDecoder (
    input  PipelinePkg::instrWord instr,
    output PipelinePkg::ctrlBits  ctrl,
    output logic                  readsRt
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl    = '0;
        readsRt = 1'b0;
        case (opcode)
            PipelinePkg::opR: begin
                readsRt = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (funct)
                    PipelinePkg::fnAdd: ctrl.aluOp = PipelinePkg::aluAdd;
                    PipelinePkg::fnSub: ctrl.aluOp = PipelinePkg::aluSub;
                    PipelinePkg::fnAnd: ctrl.aluOp = PipelinePkg::aluAnd;
                    PipelinePkg::fnOr:  ctrl.aluOp = PipelinePkg::aluOr;
                    PipelinePkg::fnSlt: ctrl.aluOp = PipelinePkg::aluSlt;
                    // Unsupported function, nop
                    default: ctrl = '0;
                endcase
            end
            PipelinePkg::opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            PipelinePkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            PipelinePkg::opSw: begin
                readsRt = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            PipelinePkg::opBeq: begin
                // Compare happens in decode
                readsRt = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.aluOp  = PipelinePkg::aluSub;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== logic/RegisterFile.sv ====
`timescale 1ns/1ps

module RegisterFile (
    input  logic               Clk,
    input  logic               rst,
    input  PipelinePkg::regIdx raddrA,
    input  PipelinePkg::regIdx raddrB,
    input  logic               we,
    input  PipelinePkg::regIdx waddr,
    input  PipelinePkg::word   wdata,
    output PipelinePkg::word   rdataA,
    output PipelinePkg::word   rdataB
);

    PipelinePkg::word regs [32];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Reg 0 reads zero, a same-cycle write shows through
    always_comb begin
        if (raddrA == '0) begin
            rdataA = '0;
        end else if (we && (waddr == raddrA)) begin
            rdataA = wdata;
        end else begin
            rdataA = regs[raddrA];
        end
        if (raddrB == '0) begin
            rdataB = '0;
        end else if (we && (waddr == raddrB)) begin
            rdataB = wdata;
        end else begin
            rdataB = regs[raddrB];
        end
    end

endmodule

// ==== logic/Alu.sv ====
`timescale 1ns/1ps

module Alu (
    input  PipelinePkg::aluOp op,
    input  PipelinePkg::word  a,
    input  PipelinePkg::word  b,
    output PipelinePkg::word  y
);

    always_comb begin
        case (op)
            // Wraps, no overflow trap
            PipelinePkg::aluAdd: y = a + b;
            PipelinePkg::aluSub: y = a - b;
            PipelinePkg::aluAnd: y = a & b;
            PipelinePkg::aluOr:  y = a | b;
            // Signed compare
            PipelinePkg::aluSlt: begin
                y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: y = '0;
        endcase
    end

endmodule

// ==== logic/PipelineCore.sv ====
`timescale 1ns/1ps

module PipelineCore #(
    parameter int LenBits = 7
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic [LenBits-1:0]    progLen,
    input  PipelinePkg::instrWord imemData,
    input  PipelinePkg::word      dmemRdata,
    output PipelinePkg::pcValue   imemAddr,
    output PipelinePkg::word      dmemAddr,
    output PipelinePkg::word      dmemWdata,
    output logic                  dmemWe,
    output logic                  wbValid,
    output PipelinePkg::regIdx    wbReg,
    output PipelinePkg::word      wbData
);

    PipelinePkg::pcValue  pc;
    PipelinePkg::ifIdReg  ifId;
    PipelinePkg::idExReg  idEx;
    PipelinePkg::exMemReg exMem;
    PipelinePkg::memWbReg memWb;

    logic                  fetchValid;
    PipelinePkg::instrWord idInstr;
    PipelinePkg::ctrlBits  idCtrl;
    logic                  idReadsRt;
    PipelinePkg::regIdx    idRs, idRt, idRdField, idDest;
    PipelinePkg::word      idImm, rdataA, rdataB, brA, brB;
    PipelinePkg::pcValue   branchTarget;
    logic                  branchTaken, stall, wbWe;
    logic [1:0]            forwardA, forwardB;
    logic                  forwardC, forwardD, forwardE, forwardF;
    PipelinePkg::word      exA, exRtFwd, exB, aluOut, exStore, memResult;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    assign imemAddr = pc;
    // Bubbles once past the loaded program
    assign fetchValid = (pc >> 2) < PipelinePkg::pcValue'(progLen);

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!stall) begin
            if (branchTaken) begin
                // Drop the instruction fetched behind the branch
                pc         <= branchTarget;
                ifId.valid <= 1'b0;
            end else begin
                ifId.valid <= fetchValid;
                ifId.pc    <= pc;
                ifId.instr <= imemData;
                if (fetchValid) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode, register read and branch resolve
    ////////////////////////////////////////////////////////////

    // Empty slot decodes as nop
    assign idInstr   = ifId.valid ? ifId.instr : '0;
    assign idRs      = idInstr[25:21];
    assign idRt      = idInstr[20:16];
    assign idRdField = idInstr[15:11];
    assign idImm     = {{16{idInstr[15]}}, idInstr[15:0]};
    assign idDest    = idCtrl.regDst ? idRdField : idRt;

    ControlDecoder decoder (.instr(idInstr), .ctrl(idCtrl), .readsRt(idReadsRt));

    RegisterFile regFile (
        .Clk(Clk), .rst(rst),
        .raddrA(idRs), .raddrB(idRt),
        .we(wbWe), .waddr(memWb.rd), .wdata(memWb.result),
        .rdataA(rdataA), .rdataB(rdataB)
    );

    HazardDetector hazard (
        .idRs(idRs), .idRt(idRt), .exRd(idEx.rd), .memRd(exMem.rd),
        .idReadsRt(idReadsRt), .idBranch(idCtrl.branch),
        .exMemRead(idEx.ctrl.memRead), .exRegWrite(idEx.ctrl.regWrite),
        .memMemRead(exMem.ctrl.memRead), .stall(stall)
    );

    // Wb values already arrive through the register file
    assign brA = forwardE ? exMem.aluOut : rdataA;
    assign brB = forwardF ? exMem.aluOut : rdataB;
    assign branchTaken  = idCtrl.branch && (brA == brB);
    assign branchTarget = ifId.pc + 32'd4 + {idImm[29:0], 2'b00};

    always_ff @(posedge Clk) begin
        if (rst || stall) begin
            // Stall slips a bubble into Ex
            idEx <= '0;
        end else begin
            idEx.valid <= ifId.valid;
            idEx.ctrl  <= idCtrl;
            idEx.rs    <= idRs;
            idEx.rt    <= idRt;
            idEx.rd    <= idDest;
            idEx.rsVal <= rdataA;
            idEx.rtVal <= rdataB;
            idEx.imm   <= idImm;
        end
    end

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    ForwardingUnit forwarding (
        .exRs(idEx.rs), .exRt(idEx.rt), .idRs(idRs), .idRt(idRt),
        .memRd(exMem.rd), .wbRd(memWb.rd),
        .aluSrc(idEx.ctrl.aluSrc), .memWriteEx(idEx.ctrl.memWrite),
        .regWriteMem(exMem.ctrl.regWrite), .memReadMem(exMem.ctrl.memRead),
        .memWriteMem(exMem.ctrl.memWrite), .regWriteWb(memWb.ctrl.regWrite),
        .branch(idCtrl.branch),
        .forwardA(forwardA), .forwardB(forwardB), .forwardC(forwardC),
        .forwardD(forwardD), .forwardE(forwardE), .forwardF(forwardF)
    );

    // 10 from Mem, 01 from Wb
    assign exA = (forwardA == 2'b10) ? exMem.aluOut :
                 (forwardA == 2'b01) ? memWb.result : idEx.rsVal;
    assign exRtFwd = (forwardB == 2'b10) ? exMem.aluOut :
                     (forwardB == 2'b01) ? memWb.result : idEx.rtVal;
    assign exB     = idEx.ctrl.aluSrc ? idEx.imm : exRtFwd;
    // A Mem producer is caught by forwardD a cycle later
    assign exStore = forwardC ? memWb.result : idEx.rtVal;

    Alu alu (.op(idEx.ctrl.aluOp), .a(exA), .b(exB), .y(aluOut));

    always_ff @(posedge Clk) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.valid    <= idEx.valid;
            exMem.ctrl     <= idEx.ctrl;
            exMem.rd       <= idEx.rd;
            exMem.aluOut   <= aluOut;
            exMem.storeVal <= exStore;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////

    assign dmemAddr  = exMem.aluOut;
    assign dmemWe    = exMem.valid && exMem.ctrl.memWrite;
    assign dmemWdata = forwardD ? memWb.result : exMem.storeVal;
    assign memResult = exMem.ctrl.memRead ? dmemRdata : exMem.aluOut;

    always_ff @(posedge Clk) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb.valid  <= exMem.valid;
            memWb.ctrl   <= exMem.ctrl;
            memWb.rd     <= exMem.rd;
            memWb.result <= memResult;
        end
    end

    assign wbWe    = memWb.valid && memWb.ctrl.regWrite;
    // Writes to r0 are not reported
    assign wbValid = wbWe && (memWb.rd != '0);
    assign wbReg   = memWb.rd;
    assign wbData  = memWb.result;

endmodule

// ==== logic/PipelineTop.sv ====
`timescale 1ns/1ps

module PipelineTop #(
    parameter int ImemWords = 64,
    parameter int DmemWords = 64
) (
    input  logic                           Clk,
    input  logic                           rst,
    input  logic                           loadEn,
    input  logic [$clog2(ImemWords)-1:0]   loadAddr,
    input  PipelinePkg::instrWord          loadInstr,
    input  logic [$clog2(ImemWords):0]     progLen,
    output logic                           wbValid,
    output PipelinePkg::regIdx             wbReg,
    output PipelinePkg::word               wbData,
    output logic                           storeValid,
    output PipelinePkg::word               storeAddr,
    output PipelinePkg::word               storeData
);

    localparam int ImemAw = $clog2(ImemWords);
    localparam int DmemAw = $clog2(DmemWords);

    PipelinePkg::instrWord imem [ImemWords];
    PipelinePkg::word      dmem [DmemWords];

    PipelinePkg::pcValue   imemAddr;
    PipelinePkg::instrWord imemData;
    PipelinePkg::word      dmemAddr, dmemWdata, dmemRdata;
    logic                  dmemWe;

    // Program load only while held in reset
    always_ff @(posedge Clk) begin
        if (rst && loadEn) begin
            imem[loadAddr] <= loadInstr;
        end
    end

    assign imemData = imem[imemAddr[ImemAw+1:2]];

    // Word addressed data memory
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < DmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (dmemWe) begin
            dmem[dmemAddr[DmemAw+1:2]] <= dmemWdata;
        end
    end

    assign dmemRdata = dmem[dmemAddr[DmemAw+1:2]];

    PipelineCore #(.LenBits(ImemAw + 1)) core (
        .Clk(Clk), .rst(rst), .progLen(progLen),
        .imemData(imemData), .dmemRdata(dmemRdata),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
        .dmemWe(dmemWe), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    // Store strobe straight from the memory stage
    assign storeValid = dmemWe;
    assign storeAddr  = dmemAddr;
    assign storeData  = dmemWdata;

endmodule

// ==== verification/ProgramGen.svh ====
`ifndef PROGRAM_GEN_SVH
`define PROGRAM_GEN_SVH

// Expected retirement events
typedef struct packed {
    PipelinePkg::regIdx dest;
    PipelinePkg::word   data;
} writeEvent;

typedef struct packed {
    PipelinePkg::word addr;
    PipelinePkg::word data;
} storeEvent;

PipelinePkg::instrWord progMem [ProgLen];
writeEvent             expWrites [$];
storeEvent             expStores [$];

function automatic PipelinePkg::instrWord encodeR(
    input logic [5:0] fn,
    input PipelinePkg::regIdx rs,
    input PipelinePkg::regIdx rt,
    input PipelinePkg::regIdx rd
);
    return {PipelinePkg::opR, rs, rt, rd, 5'd0, fn};
endfunction

function automatic PipelinePkg::instrWord encodeI(
    input logic [5:0] op,
    input PipelinePkg::regIdx rs,
    input PipelinePkg::regIdx rt,
    input logic [15:0] imm
);
    return {op, rs, rt, imm};
endfunction

// Mostly r1..r7, r0 now and then to hit the zero register
function automatic PipelinePkg::regIdx pickReg();
    if (($urandom % 16) == 0) begin
        return '0;
    end
    return PipelinePkg::regIdx'(1 + ($urandom % 7));
endfunction

function automatic void generateProgram();
    PipelinePkg::regIdx rs;
    PipelinePkg::regIdx rt;
    PipelinePkg::regIdx rd;
    logic [5:0]         fn;
    logic [15:0]        imm;
    int                 kind;
    for (int i = 0; i < ProgLen; i++) begin
        rs = pickReg();
        rt = pickReg();
        rd = pickReg();
        kind = $urandom % 10;
        if (kind < 4) begin
            case ($urandom % 5)
                0: fn = PipelinePkg::fnAdd;
                1: fn = PipelinePkg::fnSub;
                2: fn = PipelinePkg::fnAnd;
                3: fn = PipelinePkg::fnOr;
                default: fn = PipelinePkg::fnSlt;
            endcase
            progMem[i] = encodeR(fn, rs, rt, rd);
        end else if (kind < 6) begin
            // Small signed immediates
            imm = 16'($urandom % 512) - 16'd256;
            progMem[i] = encodeI(PipelinePkg::opAddi, rs, rt, imm);
        end else if (kind < 8) begin
            // Base r0, a handful of words so loads meet stores
            imm = 16'(($urandom % 16) * 4);
            progMem[i] = encodeI(PipelinePkg::opLw, 5'd0, rt, imm);
        end else if (kind == 8) begin
            imm = 16'(($urandom % 16) * 4);
            progMem[i] = encodeI(PipelinePkg::opSw, 5'd0, rt, imm);
        end else begin
            // Same register on both sides forces some taken branches
            if (($urandom % 3) == 0) begin
                rt = rs;
            end
            imm = 16'($urandom % 4);
            progMem[i] = encodeI(PipelinePkg::opBeq, rs, rt, imm);
        end
    end
endfunction

// In-order reference, fills both expected queues
function automatic void runModel();
    PipelinePkg::word      regs [32];
    PipelinePkg::word      mem [DmemWords];
    PipelinePkg::instrWord ins;
    PipelinePkg::regIdx    rs;
    PipelinePkg::regIdx    rt;
    PipelinePkg::regIdx    rd;
    PipelinePkg::word      a;
    PipelinePkg::word      b;
    PipelinePkg::word      imm;
    PipelinePkg::word      addr;
    writeEvent             wr;
    storeEvent             st;
    int                    pc;
    expWrites.delete();
    expStores.delete();
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    for (int m = 0; m < DmemWords; m++) begin
        mem[m] = '0;
    end
    pc = 0;
    while (pc < ProgLen) begin
        ins = progMem[pc];
        rs  = ins[25:21];
        rt  = ins[20:16];
        rd  = ins[15:11];
        a   = regs[rs];
        b   = regs[rt];
        imm = {{16{ins[15]}}, ins[15:0]};
        pc++;
        wr.dest = '0;
        case (ins[31:26])
            PipelinePkg::opR: begin
                wr.dest = rd;
                case (ins[5:0])
                    PipelinePkg::fnAdd: wr.data = a + b;
                    PipelinePkg::fnSub: wr.data = a - b;
                    PipelinePkg::fnAnd: wr.data = a & b;
                    PipelinePkg::fnOr:  wr.data = a | b;
                    PipelinePkg::fnSlt: wr.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr.dest = '0;
                endcase
            end
            PipelinePkg::opAddi: begin
                wr.dest = rt;
                wr.data = a + imm;
            end
            PipelinePkg::opLw: begin
                addr    = a + imm;
                wr.dest = rt;
                wr.data = mem[(addr >> 2) % DmemWords];
            end
            PipelinePkg::opSw: begin
                addr = a + imm;
                mem[(addr >> 2) % DmemWords] = b;
                st.addr = addr;
                st.data = b;
                expStores.push_back(st);
            end
            PipelinePkg::opBeq: begin
                // Offset counts words past the next instruction
                if (a == b) begin
                    pc += int'(ins[15:0]);
                end
            end
            default: wr.dest = '0;
        endcase
        // r0 never changes and is never reported
        if (wr.dest != '0) begin
            regs[wr.dest] = wr.data;
            expWrites.push_back(wr);
        end
    end
endfunction

`endif

// ==== verification/PipelineTb.sv ====
`timescale 1ns/1ps

module PipelineTb;

    localparam int ImemWords   = 64;
    localparam int DmemWords   = 64;
    localparam int ProgLen     = 40;
    localparam int NumProgs    = 20;
    localparam int ResetCycles = 10;
    localparam int IdleCycles  = 8;
    localparam int Seed        = 67862;
    // 4 cycles per instruction, plus load, reset and drain per program
    localparam int CycleLimit  =
        NumProgs * (ProgLen * 4 + ProgLen + ResetCycles + IdleCycles);

    logic                  Clk;
    logic                  rst;
    logic                  loadEn;
    logic [5:0]            loadAddr;
    PipelinePkg::instrWord loadInstr;
    logic [6:0]            progLen;
    logic                  wbValid;
    PipelinePkg::regIdx    wbReg;
    PipelinePkg::word      wbData;
    logic                  storeValid;
    PipelinePkg::word      storeAddr;
    PipelinePkg::word      storeData;

    int cycles      = 0;
    int writesSeen  = 0;
    int storesSeen  = 0;

    `include "ProgramGen.svh"

    writeEvent nextWrite;
    storeEvent nextStore;

    PipelineTop #(
        .ImemWords(ImemWords),
        .DmemWords(DmemWords)
    ) DUT (
        .Clk(Clk),
        .rst(rst),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadInstr(loadInstr),
        .progLen(progLen),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .storeValid(storeValid),
        .storeAddr(storeAddr),
        .storeData(storeData)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #10 Clk = ~Clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWrite(
        input PipelinePkg::regIdx expReg,
        input PipelinePkg::word   expData,
        input PipelinePkg::regIdx gotReg,
        input PipelinePkg::word   gotData
    );
        if (gotReg !== expReg) begin
            abortRun($sformatf("ERROR: wbReg expected %h got %h (write %0d)",
                               expReg, gotReg, writesSeen));
        end else if (gotData !== expData) begin
            abortRun($sformatf("ERROR: wbData expected %h got %h (write %0d, r%0d)",
                               expData, gotData, writesSeen, expReg));
        end
    endtask

    task automatic checkStore(
        input PipelinePkg::word expAddr,
        input PipelinePkg::word expData,
        input PipelinePkg::word gotAddr,
        input PipelinePkg::word gotData
    );
        if (gotAddr !== expAddr) begin
            abortRun($sformatf("ERROR: storeAddr expected %h got %h (store %0d)",
                               expAddr, gotAddr, storesSeen));
        end else if (gotData !== expData) begin
            abortRun($sformatf("ERROR: storeData expected %h got %h (store %0d)",
                               expData, gotData, storesSeen));
        end
    endtask

    // Outputs come from pipeline registers, sampled on the rising edge
    always @(posedge Clk) begin
        if (!rst && wbValid) begin
            if (expWrites.size() == 0) begin
                abortRun($sformatf("Register write to r%0d that the program never makes",
                                   wbReg));
            end else begin
                nextWrite = expWrites.pop_front();
                checkWrite(nextWrite.dest, nextWrite.data, wbReg, wbData);
                writesSeen++;
            end
        end
        if (!rst && storeValid) begin
            if (expStores.size() == 0) begin
                abortRun($sformatf("Store to address %h that the program never makes",
                                   storeAddr));
            end else begin
                nextStore = expStores.pop_front();
                checkStore(nextStore.addr, nextStore.data, storeAddr, storeData);
                storesSeen++;
            end
        end
    end

    // Watchdog
    always @(posedge Clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles, %0d writes and %0d stores missing",
                               cycles, expWrites.size(), expStores.size()));
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Reset held through the load, then ResetCycles more
    task automatic loadProgram();
        @(negedge Clk);
        rst     = 1'b1;
        progLen = 7'(ProgLen);
        for (int i = 0; i < ProgLen; i++) begin
            loadEn    = 1'b1;
            loadAddr  = 6'(i);
            loadInstr = progMem[i];
            @(negedge Clk);
        end
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadInstr = '0;
        repeat (ResetCycles) @(negedge Clk);
        rst = 1'b0;
    endtask

    // Done when every expected event retired, then a quiet tail
    task automatic drainProgram();
        while (expWrites.size() != 0 || expStores.size() != 0) begin
            @(negedge Clk);
        end
        repeat (IdleCycles) @(negedge Clk);
    endtask

    initial begin
        int seedDummy;
        seedDummy = $urandom(Seed);
        rst       = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadInstr = '0;
        progLen   = '0;
        for (int p = 0; p < NumProgs; p++) begin
            generateProgram();
            runModel();
            loadProgram();
            drainProgram();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verification
logic/PipelinePkg.sv
logic/ForwardingUnit.sv
logic/HazardDetector.sv
logic/ControlDecoder.sv
logic/RegisterFile.sv
logic/Alu.sv
logic/PipelineCore.sv
logic/PipelineTop.sv
verification/PipelineTb.sv

// ==== Bender.yml ====
package:
  name: pipeline_core

sources:
  - logic/PipelinePkg.sv
  - logic/ForwardingUnit.sv
  - logic/HazardDetector.sv
  - logic/ControlDecoder.sv
  - logic/RegisterFile.sv
  - logic/Alu.sv
  - logic/PipelineCore.sv
  - logic/PipelineTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/PipelineTb.sv
